//--- build.f
logic/gfx_pkg.sv
logic/host_pkg.sv
logic/refresh_regs.sv
logic/object_sequencer.sv
logic/line_splitter.sv
logic/line_fifo.sv
logic/outcode_filter.sv
logic/vector_frontend_top.sv
tests/vector_frontend_asserts.sv
tests/vector_frontend_tb.sv

//--- logic/gfx_pkg.sv
package gfx_pkg;

    localparam int screen_w   = 640;
    localparam int screen_h   = 480;
    localparam int obj_slots  = 32;
    localparam int line_seq_w = 7;
    localparam int fifo_depth = 8;                     // line FIFO entries
    localparam int free_w     = $clog2(fifo_depth) + 1; // free count spans 0..depth

    typedef logic signed [15:0] coord_t;

    typedef struct packed {
        coord_t y;
        coord_t x;                                      // x in the low half
    } point_t;

    typedef enum logic [1:0] {
        obj_point = 2'd0,
        obj_line  = 2'd1,
        obj_tri   = 2'd2,
        obj_quad  = 2'd3
    } obj_kind_t;

    // 144 bits, p0 in the lsbs, kind in [143:142]
    typedef struct packed {
        obj_kind_t   kind;
        logic [5:0]  rsvd;
        logic [7:0]  colour;
        point_t      p3;
        point_t      p2;
        point_t      p1;
        point_t      p0;
    } object_t;

    typedef struct packed {
        logic above;
        logic below;
        logic right;
        logic left;
    } outcode_t;

    typedef struct packed {
        point_t      p_a;
        point_t      p_b;
        logic [7:0]  colour;
        outcode_t    oc_a;
        outcode_t    oc_b;
    } line_t;

    // edge lines produced per object
    function automatic logic [2:0] line_count(obj_kind_t kind);
        case (kind)
            obj_tri:  return 3'd3;
            obj_quad: return 3'd4;
            default:  return 3'd1;
        endcase
    endfunction

endpackage

//--- logic/host_pkg.sv
package host_pkg;

    localparam int axil_addr_w = 8;
    localparam int axil_data_w = 32;

    typedef struct packed {
        logic [axil_addr_w-1:0]   awaddr;
        logic                     awvalid;
        logic [axil_data_w-1:0]   wdata;
        logic [axil_data_w/8-1:0] wstrb;
        logic                     wvalid;
        logic                     bready;
        logic [axil_addr_w-1:0]   araddr;
        logic                     arvalid;
        logic                     rready;
    } axil_req_t;

    typedef struct packed {
        logic                     awready;
        logic                     wready;
        logic [1:0]               bresp;
        logic                     bvalid;
        logic                     arready;
        logic [axil_data_w-1:0]   rdata;
        logic [1:0]               rresp;
        logic                     rvalid;
    } axil_rsp_t;

    localparam logic [axil_addr_w-1:0] reg_obj_word0  = 8'h00;
    localparam logic [axil_addr_w-1:0] reg_obj_word1  = 8'h04;
    localparam logic [axil_addr_w-1:0] reg_obj_word2  = 8'h08;
    localparam logic [axil_addr_w-1:0] reg_obj_word3  = 8'h0C;
    localparam logic [axil_addr_w-1:0] reg_obj_word4  = 8'h10;
    localparam logic [axil_addr_w-1:0] reg_obj_commit = 8'h14;
    localparam logic [axil_addr_w-1:0] reg_obj_count  = 8'h18;
    localparam logic [axil_addr_w-1:0] reg_ctrl       = 8'h1C;
    localparam logic [axil_addr_w-1:0] reg_status     = 8'h20;
    localparam logic [axil_addr_w-1:0] reg_dropped    = 8'h24;

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

endpackage

//--- logic/line_fifo.sv
`timescale 1ns/1ps

module line_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 8
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wr_en,
    input  payload_t               wr_data,
    input  logic                   rd_en,
    output payload_t               rd_data,
    output logic                   rd_valid,
    output logic [$clog2(depth):0] free,
    output logic                   empty
);
    localparam int aw = $clog2(depth);

    payload_t      mem [depth];
    logic [aw-1:0] wr_ptr;
    logic [aw-1:0] rd_ptr;
    logic [aw:0]   count;
    logic          do_wr;
    logic          do_rd;

    if (depth < 4 || (depth & (depth - 1)) != 0) begin : g_bad_depth
        $error("line_fifo depth must be a power of two, at least 4");
    end

    assign empty    = count == '0;
    assign rd_valid = !empty;
    assign rd_data  = mem[rd_ptr];     // head entry, no read latency
    assign free     = (aw + 1)'(depth) - count;
    assign do_wr    = wr_en && count != (aw + 1)'(depth);
    assign do_rd    = rd_en && !empty;

    always_ff @(posedge clk) begin
        if (do_wr)
            mem[wr_ptr] <= wr_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;   // pointers wrap on power of two
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + (aw + 1)'(do_wr) - (aw + 1)'(do_rd);
        end
    end

endmodule

//--- logic/line_splitter.sv
`timescale 1ns/1ps

module line_splitter (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [1:0]                     phase,
    input  gfx_pkg::object_t               obj_data,
    input  logic                           obj_vld,
    input  logic                           start,
    output logic                           wr_en,
    output gfx_pkg::line_t                 wr_data,
    output logic [gfx_pkg::line_seq_w-1:0] line_cnt
);
    import gfx_pkg::*;

    object_t obj_q;
    logic    have_q;
    logic    issue;
    point_t  end_a;
    point_t  end_b;

    function automatic outcode_t outcode(point_t p);
        outcode_t oc;
        oc.above = p.y > coord_t'(screen_h);
        oc.below = p.y < 0;
        oc.right = p.x > coord_t'(screen_w);
        oc.left  = p.x < 0;
        return oc;
    endfunction

    always_ff @(posedge clk) begin
        if (obj_vld && phase == 2'd3)
            obj_q <= obj_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            have_q   <= 1'b0;
            line_cnt <= '0;
        end else begin
            if (phase == 2'd3)
                have_q <= obj_vld;   // one slot per object
            if (start)
                line_cnt <= '0;
            else if (wr_en)
                line_cnt <= line_cnt + 1'b1;  // wraps
        end
    end

    // edge select by phase
    always_comb begin
        issue = 1'b0;
        end_a = obj_q.p0;
        end_b = obj_q.p1;
        case (phase)
            2'd0: begin
                issue = 1'b1;
                end_b = (obj_q.kind == obj_point) ? obj_q.p0 : obj_q.p1;
            end
            2'd1: begin
                issue = obj_q.kind == obj_tri || obj_q.kind == obj_quad;
                end_a = obj_q.p1;
                end_b = obj_q.p2;
            end
            2'd2: begin
                issue = obj_q.kind == obj_tri || obj_q.kind == obj_quad;
                end_a = obj_q.p2;
                end_b = (obj_q.kind == obj_tri) ? obj_q.p0 : obj_q.p3;
            end
            default: begin
                issue = obj_q.kind == obj_quad;  // closing edge of a quad
                end_a = obj_q.p3;
                end_b = obj_q.p0;
            end
        endcase
    end

    assign wr_en   = have_q && issue;
    assign wr_data = '{p_a: end_a, p_b: end_b, colour: obj_q.colour,
                       oc_a: outcode(end_a), oc_b: outcode(end_b)};

endmodule

//--- logic/object_sequencer.sv
`timescale 1ns/1ps

module object_sequencer (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       obj_wr,
    input  logic [4:0]                 obj_wr_idx,
    input  gfx_pkg::object_t           obj_wr_data,
    input  logic [5:0]                 obj_count,
    input  logic                       start,
    input  logic [gfx_pkg::free_w-1:0] free,
    input  logic                       drain_done,
    output logic [1:0]                 phase,
    output gfx_pkg::object_t           obj_data,
    output logic                       obj_vld,
    output logic                       busy
);
    import gfx_pkg::*;

    object_t           store [obj_slots];
    logic [5:0]        count_q;
    logic [5:0]        obj_idx;
    logic              run_q;
    logic              slot_q;       // a fetch belongs to the current slot
    logic [free_w-1:0] need;
    logic              slot_go;

    // the object fetched last slot is still being split during this one,
    // so room for its lines plus a full quad is reserved
    assign need    = slot_q ? free_w'(4 + line_count(obj_data.kind)) : free_w'(4);
    assign slot_go = run_q && phase == 2'd0 && obj_idx != count_q && free >= need;

    always_ff @(posedge clk) begin
        if (obj_wr)
            store[obj_wr_idx] <= obj_wr_data;
        if (slot_q && phase == 2'd2)
            obj_data <= store[obj_idx[4:0]];  // one cycle read
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase   <= 2'd0;
            count_q <= '0;
            obj_idx <= '0;
            run_q   <= 1'b0;
            slot_q  <= 1'b0;
            obj_vld <= 1'b0;
            busy    <= 1'b0;
        end else begin
            phase   <= phase + 2'd1;
            obj_vld <= slot_q && phase == 2'd2;  // high in phase 3
            if (start) begin
                run_q   <= 1'b1;
                busy    <= 1'b1;
                obj_idx <= '0;
                count_q <= obj_count;
            end else begin
                if (phase == 2'd0) begin
                    slot_q <= slot_go;
                    // previous slot idle, so every line is in the FIFO
                    if (run_q && !slot_q && obj_idx == count_q)
                        run_q <= 1'b0;
                end
                if (slot_q && phase == 2'd2)
                    obj_idx <= obj_idx + 6'd1;
                if (busy && !run_q && drain_done)
                    busy <= 1'b0;
            end
        end
    end

endmodule

//--- logic/outcode_filter.sv
`timescale 1ns/1ps

module outcode_filter (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           rd_valid,
    input  gfx_pkg::line_t rd_data,
    output logic           rd_en,
    output gfx_pkg::line_t out_line,
    output logic           out_valid,
    input  logic           out_ready,
    output logic           drop_pulse,
    output logic           idle
);

    logic reject;

    // pop when the output slot is empty or leaving this cycle
    assign rd_en  = rd_valid && (!out_valid || out_ready);
    assign reject = |(rd_data.oc_a & rd_data.oc_b);  // both ends off the same edge
    assign idle   = !out_valid;

    always_ff @(posedge clk) begin
        if (rd_en && !reject)
            out_line <= rd_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid  <= 1'b0;
            drop_pulse <= 1'b0;
        end else begin
            drop_pulse <= rd_en && reject;
            if (rd_en && !reject)
                out_valid <= 1'b1;
            else if (out_ready)
                out_valid <= 1'b0;
        end
    end

endmodule

//--- logic/refresh_regs.sv
`timescale 1ns/1ps

module refresh_regs (
    input  logic                           clk,
    input  logic                           rst_n,
    input  host_pkg::axil_req_t            host_req,
    output host_pkg::axil_rsp_t            host_rsp,
    output logic                           obj_wr,
    output logic [4:0]                     obj_wr_idx,
    output gfx_pkg::object_t               obj_wr_data,
    output logic [5:0]                     obj_count,
    output logic                           start,
    input  logic                           busy,
    input  logic [gfx_pkg::line_seq_w-1:0] line_cnt,
    input  logic                           drop_pulse
);
    import host_pkg::*;
    import gfx_pkg::*;

    logic [4:0][31:0] stage_q;       // object staging words
    logic [159:0]     stage_flat;
    logic [31:0]      dropped_q;
    logic             wr_fire;
    logic             rd_fire;
    logic             wr_hit;
    logic             rd_hit;
    logic             stage_sel;
    logic [31:0]      rd_word;
    logic             bvalid_q;
    logic             rvalid_q;
    logic [1:0]       bresp_q;
    logic [1:0]       rresp_q;
    logic [31:0]      rdata_q;

    assign wr_fire = host_req.awvalid && host_req.wvalid && !bvalid_q;
    assign rd_fire = host_req.arvalid && !rvalid_q;

    assign stage_sel  = host_req.awaddr inside {reg_obj_word0, reg_obj_word1, reg_obj_word2,
                                                reg_obj_word3, reg_obj_word4};
    assign wr_hit     = stage_sel || host_req.awaddr inside {reg_obj_commit, reg_obj_count,
                                                             reg_ctrl, reg_status, reg_dropped};
    assign stage_flat  = stage_q;
    assign obj_wr_data = stage_flat[143:0];

    always_comb begin
        rd_hit  = 1'b1;
        rd_word = '0;
        case (host_req.araddr)
            reg_obj_word0, reg_obj_word1, reg_obj_word2,
            reg_obj_word3, reg_obj_word4: rd_word = stage_q[host_req.araddr[4:2]];
            reg_obj_commit: rd_word = '0;
            reg_obj_count:  rd_word = {26'd0, obj_count};
            reg_ctrl:       rd_word = {31'd0, busy};
            reg_status:     rd_word = {17'd0, line_cnt, 7'd0, busy};
            reg_dropped:    rd_word = dropped_q;
            default:        rd_hit  = 1'b0;
        endcase
    end

    // byte-strobed staging writes
    always_ff @(posedge clk) begin
        if (wr_fire && stage_sel) begin
            for (int b = 0; b < 4; b++) begin
                if (host_req.wstrb[b])
                    stage_q[host_req.awaddr[4:2]][b*8 +: 8] <= host_req.wdata[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            obj_wr     <= 1'b0;
            obj_wr_idx <= '0;
            obj_count  <= '0;
            start      <= 1'b0;
            dropped_q  <= '0;
            bvalid_q   <= 1'b0;
            bresp_q    <= resp_okay;
            rvalid_q   <= 1'b0;
            rresp_q    <= resp_okay;
            rdata_q    <= '0;
        end else begin
            obj_wr <= 1'b0;
            start  <= 1'b0;
            if (wr_fire) begin
                bvalid_q <= 1'b1;
                bresp_q  <= wr_hit ? resp_okay : resp_slverr;
                case (host_req.awaddr)
                    reg_obj_commit: begin
                        obj_wr     <= 1'b1;
                        obj_wr_idx <= host_req.wdata[4:0];
                    end
                    reg_obj_count: obj_count <= (host_req.wdata > obj_slots) ?
                                                6'(obj_slots) : host_req.wdata[5:0];
                    reg_ctrl:      start <= host_req.wdata[0] && !busy; // ignored mid refresh
                    default: ;
                endcase
            end else if (host_req.bready) begin
                bvalid_q <= 1'b0;
            end
            if (rd_fire) begin
                rvalid_q <= 1'b1;
                rdata_q  <= rd_word;
                rresp_q  <= rd_hit ? resp_okay : resp_slverr;
            end else if (host_req.rready) begin
                rvalid_q <= 1'b0;
            end
            if (start)
                dropped_q <= '0;
            else if (drop_pulse)
                dropped_q <= dropped_q + 32'd1;
        end
    end

    always_comb begin
        host_rsp         = '0;
        host_rsp.awready = wr_fire;
        host_rsp.wready  = wr_fire;
        host_rsp.bresp   = bresp_q;
        host_rsp.bvalid  = bvalid_q;
        host_rsp.arready = rd_fire;
        host_rsp.rdata   = rdata_q;
        host_rsp.rresp   = rresp_q;
        host_rsp.rvalid  = rvalid_q;
    end

endmodule

//--- logic/vector_frontend_top.sv
`timescale 1ns/1ps

module vector_frontend_top (
    input  logic                clk,
    input  logic                rst_n,
    input  host_pkg::axil_req_t host_req,
    output host_pkg::axil_rsp_t host_rsp,
    output gfx_pkg::line_t      out_line,
    output logic                out_valid,
    input  logic                out_ready
);
    import gfx_pkg::*;

    logic                  obj_wr;
    logic [4:0]            obj_wr_idx;
    object_t               obj_wr_data;
    logic [5:0]            obj_count;
    logic                  start;
    logic                  busy;
    logic [line_seq_w-1:0] line_cnt;
    logic                  drop_pulse;
    logic [1:0]            phase;
    object_t               obj_data;
    logic                  obj_vld;
    logic                  wr_en;
    line_t                 wr_data;
    logic                  rd_en;
    line_t                 rd_data;
    logic                  rd_valid;
    logic [free_w-1:0]     free;
    logic                  fifo_empty;
    logic                  flt_idle;
    logic                  drain_done;

    assign drain_done = fifo_empty && flt_idle;

    refresh_regs u_regs (
        .clk, .rst_n, .host_req, .host_rsp,
        .obj_wr, .obj_wr_idx, .obj_wr_data, .obj_count, .start,
        .busy, .line_cnt, .drop_pulse
    );

    object_sequencer u_seq (
        .clk, .rst_n, .obj_wr, .obj_wr_idx, .obj_wr_data, .obj_count, .start,
        .free, .drain_done, .phase, .obj_data, .obj_vld, .busy
    );

    line_splitter u_split (
        .clk, .rst_n, .phase, .obj_data, .obj_vld, .start,
        .wr_en, .wr_data, .line_cnt
    );

    line_fifo #(
        .payload_t (line_t),
        .depth     (fifo_depth)
    ) u_fifo (
        .clk, .rst_n, .wr_en, .wr_data, .rd_en, .rd_data, .rd_valid,
        .free, .empty (fifo_empty)
    );

    outcode_filter u_filter (
        .clk, .rst_n, .rd_valid, .rd_data, .rd_en,
        .out_line, .out_valid, .out_ready, .drop_pulse,
        .idle (flt_idle)
    );

endmodule

//--- run.sh
#!/bin/sh
# build and run the vector front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 \
    --top-module vector_frontend_tb \
    -f build.f \
    -o vector_frontend_sim

./obj_dir/vector_frontend_sim

//--- tests/vector_frontend_asserts.sv
`timescale 1ns/1ps

module vector_frontend_asserts (
    input logic                       clk,
    input logic                       rst_n,
    input gfx_pkg::line_t             out_line,
    input logic                       out_valid,
    input logic                       out_ready,
    input logic                       wr_en,
    input logic [gfx_pkg::free_w-1:0] free,
    input logic                       busy
);

    // stalled output keeps its line
    stream_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_line))
        else $error("out_line changed while the stream was stalled");

    no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        !(wr_en && free == '0))
        else $error("line FIFO written while it had no free slot");

    busy_end: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy) |-> !out_valid)   // refresh ends with the stream empty
        else $error("busy fell while a line was still on the stream");

endmodule

bind vector_frontend_top vector_frontend_asserts u_asserts (
    .clk, .rst_n, .out_line, .out_valid, .out_ready, .wr_en, .free, .busy
);

//--- tests/vector_frontend_tb.sv
`timescale 1ns/1ps

module vector_frontend_tb;
    import gfx_pkg::*;
    import host_pkg::*;

    localparam int n_dir = 12;
    localparam int n_rnd = 20;
    // 20 x (4 x objects + 20) cycles per run with the host error run taken as empty
    localparam int limit_cycles = 20 * 20 + 2 * 20 * (4 * n_dir + 20) + 20 * (4 * n_rnd + 20);

    logic        clk = 1'b0;
    logic        rst_n;
    axil_req_t   host_req;
    axil_rsp_t   host_rsp;
    line_t       out_line;
    logic        out_valid;
    logic        out_ready = 1'b1;

    line_t       exp_q [$];
    int          got_lines = 0;
    logic        ready_random = 1'b0;
    logic [31:0] rng_obj = 32'd89779;
    logic [31:0] rng_ready = 32'd89779;

    // kind x0 y0 x1 y1 x2 y2 x3 y3 colour lines_out lines_dropped
    // kind 0 point, 1 line, 2 tri, 3 quad
    int dir_tab [n_dir][12] = '{
        '{0,  100, 100,    0,   0,   0,   0,   0,   0, 'h11, 1, 0},
        '{1,   10,  20,  600, 400,   0,   0,   0,   0, 'h22, 1, 0},
        '{2,    0,   0,  640,   0, 320, 480,   0,   0, 'h33, 3, 0},
        '{3,   50,  50,  200,  50, 200, 300,  50, 300, 'h44, 4, 0},
        '{1,  -20, 100,  700, 200,   0,   0,   0,   0, 'h55, 1, 0},
        '{1,  100,  -5,  300, 500,   0,   0,   0,   0, 'h66, 1, 0},
        '{0,   -1,  10,    0,   0,   0,   0,   0,   0, 'h77, 0, 1},
        '{1,  700,  10,  650, 470,   0,   0,   0,   0, 'h88, 0, 1},
        '{2,   10, -10,   20, -30, 300, 200,   0,   0, 'h99, 2, 1},
        '{3,  -10, 490,  -50, 500, 700, 520, 100, 100, 'haa, 2, 2},
        '{1,   -5,  -5,  645, 485,   0,   0,   0,   0, 'hbb, 1, 0},
        '{0,  640, 480,    0,   0,   0,   0,   0,   0, 'hcc, 1, 0}
    };

    vector_frontend_top dut (
        .clk, .rst_n, .host_req, .host_rsp,
        .out_line, .out_valid, .out_ready
    );

    always #5 clk = ~clk;

    task automatic check_value(input logic [79:0] got, input logic [79:0] want,
                               input string what);
        if (got !== want) begin
            $display("mismatch at time %0t: %s, got %0h, expected %0h", $time, what, got, want);
            $display("STATUS: FAIL");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic abort_run(input string why);
        $display("error at time %0t: %s", $time, why);
        $display("STATUS: FAIL");
        $fatal(1, "run aborted");
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic point_t point_at(input int x, input int y);
        point_t p;
        p.x = coord_t'(x);
        p.y = coord_t'(y);
        return p;
    endfunction

    function automatic point_t random_point();
        point_t p;
        rng_obj = lcg_next(rng_obj);
        p.x = coord_t'(int'(rng_obj[30:16]) % 841 - 100);  // -100 .. 740
        rng_obj = lcg_next(rng_obj);
        p.y = coord_t'(int'(rng_obj[30:16]) % 841 - 100);
        return p;
    endfunction

    function automatic object_t random_object();
        object_t o;
        o = '0;
        rng_obj = lcg_next(rng_obj);
        o.kind   = obj_kind_t'(rng_obj[29:28]);
        o.colour = rng_obj[23:16];
        o.p0     = random_point();
        o.p1     = random_point();
        o.p2     = random_point();
        o.p3     = random_point();
        return o;
    endfunction

    function automatic object_t table_object(input int row);
        object_t o;
        o = '0;
        o.kind   = obj_kind_t'(dir_tab[row][0][1:0]);
        o.p0     = point_at(dir_tab[row][1], dir_tab[row][2]);
        o.p1     = point_at(dir_tab[row][3], dir_tab[row][4]);
        o.p2     = point_at(dir_tab[row][5], dir_tab[row][6]);
        o.p3     = point_at(dir_tab[row][7], dir_tab[row][8]);
        o.colour = 8'(dir_tab[row][9]);
        return o;
    endfunction

    // Cohen-Sutherland code against the 640 x 480 screen
    function automatic outcode_t outcode_of(input point_t p);
        outcode_t c;
        c.above = int'(p.y) > screen_h;
        c.below = int'(p.y) < 0;
        c.right = int'(p.x) > screen_w;
        c.left  = int'(p.x) < 0;
        return c;
    endfunction

    // reference split and reject that queues the surviving lines
    task automatic predict_lines(input object_t obj, output int n_pass, output int n_drop);
        point_t pts [4];
        int     n_edges;
        line_t  ln;
        pts[0] = obj.p0;
        pts[1] = obj.p1;
        pts[2] = obj.p2;
        pts[3] = obj.p3;
        n_pass = 0;
        n_drop = 0;
        case (obj.kind)
            obj_tri:  n_edges = 3;
            obj_quad: n_edges = 4;
            default:  n_edges = 1;
        endcase
        for (int e = 0; e < n_edges; e++) begin
            ln.p_a = pts[e];
            case (obj.kind)
                obj_point: ln.p_b = pts[0];
                obj_line:  ln.p_b = pts[1];
                default:   ln.p_b = pts[(e + 1) % n_edges];  // closing edge wraps to p0
            endcase
            ln.colour = obj.colour;
            ln.oc_a   = outcode_of(ln.p_a);
            ln.oc_b   = outcode_of(ln.p_b);
            if ((4'(ln.oc_a) & 4'(ln.oc_b)) != 4'd0) begin
                n_drop++;
            end else begin
                exp_q.push_back(ln);
                n_pass++;
            end
        end
    endtask

    task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        @(negedge clk);
        host_req.awaddr  = addr;
        host_req.awvalid = 1'b1;
        host_req.wdata   = data;
        host_req.wstrb   = 4'hf;
        host_req.wvalid  = 1'b1;
        #1;
        check_value(80'({host_rsp.awready, host_rsp.wready}), 80'(2'b11),
                    "address and data ready on write");
        do @(negedge clk); while (!host_rsp.bvalid);  // bready held high
        check_value(80'({host_rsp.awready, host_rsp.wready}), 80'(2'b00),
                    "address and data ready after write accept");
        resp             = host_rsp.bresp;
        host_req.awvalid = 1'b0;
        host_req.wvalid  = 1'b0;
    endtask

    task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        @(negedge clk);
        host_req.araddr  = addr;
        host_req.arvalid = 1'b1;
        #1;
        check_value(80'(host_rsp.arready), 80'(1), "read address ready");
        do @(negedge clk); while (!host_rsp.rvalid);
        check_value(80'(host_rsp.arready), 80'(0), "read address ready after accept");
        data             = host_rsp.rdata;
        resp             = host_rsp.rresp;
        host_req.arvalid = 1'b0;
    endtask

    task automatic load_object(input int idx, input object_t obj);
        logic [1:0]   resp;
        logic [159:0] flat;
        flat = 160'(obj);
        for (int w = 0; w < 5; w++) begin
            axil_write(8'(4 * w), flat[w*32 +: 32], resp);
            check_value(80'(resp), 80'(resp_okay), "staging word write response");
        end
        axil_write(reg_obj_commit, 32'(idx), resp);
        check_value(80'(resp), 80'(resp_okay), "commit write response");
    endtask

    task automatic refresh_and_check(input int n, input int n_pass, input int n_drop,
                                     input logic random_ready);
        logic [31:0] rd;
        logic [1:0]  resp;
        axil_write(reg_obj_count, 32'(n), resp);
        check_value(80'(resp), 80'(resp_okay), "object count write response");
        got_lines    = 0;
        ready_random = random_ready;
        axil_write(reg_ctrl, 32'd1, resp);
        axil_read(reg_status, rd, resp);
        check_value(80'(rd[0]), 80'(1), "busy during refresh");
        while (rd[0])
            axil_read(reg_status, rd, resp);
        ready_random = 1'b0;
        check_value(80'(got_lines), 80'(n_pass), "lines seen on the stream");
        check_value(80'(rd[14:8]), 80'(n_pass + n_drop), "status line count");
        axil_read(reg_dropped, rd, resp);
        check_value(80'(rd), 80'(n_drop), "dropped line count");
    endtask

    task automatic run_directed(input logic random_ready);
        int np;
        int nd;
        int pass_sum;
        int drop_sum;
        pass_sum = 0;
        drop_sum = 0;
        for (int i = 0; i < n_dir; i++) begin
            load_object(i, table_object(i));
            predict_lines(table_object(i), np, nd);
            check_value(80'(np), 80'(dir_tab[i][10]), "model line count against table");
            check_value(80'(nd), 80'(dir_tab[i][11]), "model drop count against table");
            pass_sum += np;
            drop_sum += nd;
        end
        refresh_and_check(n_dir, pass_sum, drop_sum, random_ready);
    endtask

    task automatic run_random(input logic random_ready);
        object_t obj;
        int      np;
        int      nd;
        int      pass_sum;
        int      drop_sum;
        pass_sum = 0;
        drop_sum = 0;
        for (int i = 0; i < n_rnd; i++) begin
            obj = random_object();
            load_object(i, obj);
            predict_lines(obj, np, nd);
            pass_sum += np;
            drop_sum += nd;
        end
        refresh_and_check(n_rnd, pass_sum, drop_sum, random_ready);
    endtask

    task automatic check_host_errors();
        logic [31:0] rd;
        logic [1:0]  resp;
        axil_write(reg_obj_word4, 32'h1234_5678, resp);
        check_value(80'(resp), 80'(resp_okay), "word4 write response");
        axil_write(reg_obj_count, 32'd3, resp);
        check_value(80'(resp), 80'(resp_okay), "object count write response");
        axil_write(8'h30, 32'hffff_ffff, resp);
        check_value(80'(resp), 80'(resp_slverr), "unmapped write response");
        axil_read(8'h2c, rd, resp);
        check_value(80'(resp), 80'(resp_slverr), "unmapped read response");
        axil_read(reg_obj_word4, rd, resp);
        check_value(80'(rd), 80'(32'h1234_5678), "word4 after unmapped write");
        axil_read(reg_obj_count, rd, resp);
        check_value(80'(rd), 80'(3), "object count after unmapped write");
        axil_read(reg_status, rd, resp);
        check_value(80'(rd), 80'(0), "status after unmapped write");
        axil_read(reg_dropped, rd, resp);
        check_value(80'(rd), 80'(0), "dropped count after unmapped write");
    endtask

    // out_ready driven and the stream checked on the falling edge
    always @(negedge clk) begin : stream_monitor
        line_t want;
        rng_ready = lcg_next(rng_ready);
        out_ready = ready_random ? rng_ready[27] : 1'b1;
        if (out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                abort_run("a line appeared on the output stream that the model did not predict");
            end else begin
                want = exp_q.pop_front();
                check_value(80'(out_line), 80'(want), "output line");
                got_lines++;
            end
        end
    end

    initial begin : watchdog
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", limit_cycles);
        $display("STATUS: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin : main_sequence
        host_req        = '0;
        host_req.bready = 1'b1;
        host_req.rready = 1'b1;
        rst_n           = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        check_host_errors();
        run_directed(1'b0);
        run_random(1'b1);     // back-pressure on random objects
        run_directed(1'b1);   // counts must restart

        $display("STATUS: PASS");
        $finish;
    end

endmodule
